/* common/comp_rx_macros.svh */
`ifndef COMP_RX_MACROS_SVH
`define COMP_RX_MACROS_SVH

// Control characters on the fiber
`define K_START 16'h00BC  // Frame start comma
`define K_FC    16'h00FC  // Latency marker from the transmitter

// Frame and pipeline sizes
`define FRAME_WORDS 3   // Data words per comparator frame
`define DELAY_DEPTH 16  // Longest comparator delay in bx

// Link health thresholds
`define LINK_GOOD_FRAMES 16  // Clean frames in a row before link is good
`define LINK_BAD_ERRS    8   // Error count that marks the link bad

`endif

/* common/comp_rx_pkg.sv */
package comp_rx_pkg;

  // --------------------
  // Frame payload
  // --------------------

  // Three 16-bit fiber words, first word in the top bits
  typedef logic [47:0] comp_data_t;

  // Side-band bits that ride the delay line beside the data
  typedef struct packed {
    logic valid;  // Frame complete this bx
    logic fc;     // Latency "FC" word seen this bx
  } frame_tag_t;

  // --------------------
  // Register map
  // --------------------

  // Byte offsets of the AXI4-Lite registers
  typedef enum logic [3:0] {
    CONTROL   = 4'h0,  // prbs_en, pol_swap, delay_sel
    STATUS    = 4'h4,  // Link flags, read only
    ERR_COUNT = 4'h8,  // PRBS or link error count
    COMMAND   = 4'hC   // Write-one pulses
  } rx_reg_addr_t;

endpackage

/* logic/comp_frame_aligner.sv */
`timescale 1ns/10ps
`include "comp_rx_macros.svh"

module comp_frame_aligner (
  input  logic                   clock,
  input  logic                   gtx_rx_reset,
  input  logic [15:0]            rx_word,        // Deserialized fiber word
  input  logic                   rx_word_valid,
  input  logic                   rx_is_k,        // Word is a control character
  input  logic                   pol_swap,       // Swapped board route, invert data
  output comp_rx_pkg::comp_data_t frame_data,    // Assembled frame
  output logic                   frame_valid,    // Pulse, frame_data complete
  output logic                   frame_err,      // Pulse, framing violation
  output logic                   fc_seen,        // Pulse, latency word
  output logic                   sync_done       // Sticky after first start word
);

  localparam int CNT_W = $clog2(`FRAME_WORDS);

  logic             locked;     // Start word seen, frame in progress
  logic [CNT_W-1:0] word_cnt;   // Data words taken this frame
  logic [15:0]      data_word;  // Polarity-corrected data
  logic             is_start;
  logic             is_fc;
  logic             stray_k;
  logic             is_data;
  logic             last_word;

  // --------------------
  // Word decode
  // --------------------
  assign is_start  = rx_word_valid & rx_is_k & (rx_word == `K_START);
  assign is_fc     = rx_word_valid & rx_is_k & (rx_word == `K_FC);
  assign stray_k   = rx_word_valid & rx_is_k & ~is_start & ~is_fc;  // Any other comma
  assign is_data   = rx_word_valid & ~rx_is_k;
  assign data_word = pol_swap ? ~rx_word : rx_word;
  assign last_word = (word_cnt == CNT_W'(`FRAME_WORDS - 1));

  // --------------------
  // Lock and word count
  // --------------------
  always_ff @(posedge clock or posedge gtx_rx_reset) begin
    if (gtx_rx_reset) begin
      locked      <= 1'b0;
      word_cnt    <= '0;
      frame_valid <= 1'b0;
      frame_err   <= 1'b0;
      fc_seen     <= 1'b0;
      sync_done   <= 1'b0;
    end else begin
      frame_valid <= 1'b0;
      frame_err   <= 1'b0;
      fc_seen     <= is_fc;  // FC leaves framing untouched
      if (is_start) begin
        locked    <= 1'b1;   // Restart counting, even mid-frame
        word_cnt  <= '0;
        sync_done <= 1'b1;
      end else if (stray_k) begin
        frame_err <= locked;  // Only an error inside a frame
        locked    <= 1'b0;
        word_cnt  <= '0;
      end else if (is_data) begin
        if (!locked) begin
          frame_err <= 1'b1;  // Data with no start word
        end else if (last_word) begin
          frame_valid <= 1'b1;
          locked      <= 1'b0;  // Next frame needs its own start word
          word_cnt    <= '0;
        end else begin
          word_cnt <= word_cnt + 1'b1;
        end
      end
    end
  end

  // Assembly shift register, first word ends up on top
  always_ff @(posedge clock) begin
    if (is_data && locked) begin
      frame_data <= {frame_data[$bits(frame_data)-17:0], data_word};
    end
  end

  // A frame needs three words, so frames and errors never coincide or run back to back
  assert property (@(posedge clock) disable iff (gtx_rx_reset)
    frame_valid |-> !frame_err ##1 !frame_valid);

endmodule

/* logic/link_monitor.sv */
`timescale 1ns/10ps
`include "comp_rx_macros.svh"

module link_monitor (
  input  logic       clock,
  input  logic       gtx_rx_reset,
  input  logic       frame_valid,    // Good frame from aligner
  input  logic       frame_err,      // Framing error from aligner
  input  logic       clear,          // Register command
  input  logic       ttc_resync,     // Resync from TTC
  output logic [7:0] link_errcount,  // Saturating error count
  output logic       link_good,
  output logic       link_bad,
  output logic       link_had_err    // Sticky
);

  localparam int RUN_W = $clog2(`LINK_GOOD_FRAMES + 1);

  logic [RUN_W-1:0] run_cnt;   // Consecutive clean frames, saturates at threshold
  logic [7:0]       err_next;  // Count after this error
  logic             clr;

  assign clr      = clear | ttc_resync;
  assign err_next = (link_errcount == 8'hFF) ? link_errcount : link_errcount + 8'd1;

  // --------------------
  // Error count and flags
  // --------------------
  always_ff @(posedge clock or posedge gtx_rx_reset) begin
    if (gtx_rx_reset) begin
      link_errcount <= '0;
      link_bad      <= 1'b0;
      link_had_err  <= 1'b0;
    end else if (clr) begin
      link_errcount <= '0;  // Clear wins over a same-cycle error
      link_bad      <= 1'b0;
      link_had_err  <= 1'b0;
    end else if (frame_err) begin
      link_errcount <= err_next;
      link_bad      <= link_bad | (err_next >= 8'(`LINK_BAD_ERRS));
      link_had_err  <= 1'b1;
    end
  end

  // --------------------
  // Good-run tracking
  // --------------------
  // link_good follows the run counter, which a clear keeps
  always_ff @(posedge clock or posedge gtx_rx_reset) begin
    if (gtx_rx_reset) begin
      run_cnt   <= '0;
      link_good <= 1'b0;
    end else if (frame_err) begin
      run_cnt   <= '0;  // Any error restarts the run
      link_good <= 1'b0;
    end else if (frame_valid && (run_cnt != RUN_W'(`LINK_GOOD_FRAMES))) begin
      run_cnt <= run_cnt + 1'b1;
      if (run_cnt == RUN_W'(`LINK_GOOD_FRAMES - 1)) begin
        link_good <= 1'b1;
      end
    end
  end

endmodule

/* logic/prbs_checker.sv */
`timescale 1ns/10ps

module prbs_checker (
  input  logic                    clock,
  input  logic                    gtx_rx_reset,
  input  logic                    enable,         // PRBS self-test mode
  input  logic                    clear,          // Register command
  input  logic                    ttc_resync,     // Resync from TTC
  input  comp_rx_pkg::comp_data_t frame_data,
  input  logic                    frame_valid,
  output logic [15:0]             prbs_errcount,  // Saturating mismatch count
  output logic                    prbs_err        // Pulse per mismatch
);

  import comp_rx_pkg::*;

  comp_data_t prev_frame;  // Last received frame
  comp_data_t expected;    // Next LFSR state from prev_frame
  logic       seeded;      // prev_frame holds a real frame
  logic       clr;
  logic       mismatch;

  // One Fibonacci step, taps 48/47/21/20
  function automatic comp_data_t lfsr_step(input comp_data_t s);
    return {s[46:0], s[47] ^ s[46] ^ s[20] ^ s[19]};
  endfunction

  assign clr      = clear | ttc_resync;
  assign expected = lfsr_step(prev_frame);
  assign mismatch = enable & frame_valid & seeded & (frame_data != expected);

  always_ff @(posedge clock or posedge gtx_rx_reset) begin
    if (gtx_rx_reset) begin
      seeded        <= 1'b0;
      prbs_errcount <= '0;
      prbs_err      <= 1'b0;
    end else begin
      prbs_err <= mismatch & ~clr;
      if (clr || !enable) seeded <= 1'b0;  // First frame after this reseeds
      else if (frame_valid) seeded <= 1'b1;
      if (clr) begin
        prbs_errcount <= '0;
      end else if (mismatch && (prbs_errcount != 16'hFFFF)) begin
        prbs_errcount <= prbs_errcount + 16'd1;
      end
    end
  end

  // Compare each frame against its received predecessor
  always_ff @(posedge clock) begin
    if (enable && frame_valid) prev_frame <= frame_data;
  end

endmodule

/* logic/bx_delay_line.sv */
`timescale 1ns/10ps
`include "comp_rx_macros.svh"

module bx_delay_line #(
  parameter type payload_t = logic  // Data or tag payload
) (
  input  logic       clock,
  input  logic       gtx_rx_reset,
  input  logic [3:0] delay_sel,  // Tap, delay is delay_sel + 1
  input  logic       zero_in,    // Untrusted link, shift in zeros
  input  payload_t   d,
  output payload_t   q
);

  payload_t taps [`DELAY_DEPTH];  // taps[0] is one bx old

  always_ff @(posedge clock or posedge gtx_rx_reset) begin
    if (gtx_rx_reset) begin
      for (int i = 0; i < `DELAY_DEPTH; i++) begin
        taps[i] <= '0;
      end
    end else begin
      taps[0] <= zero_in ? payload_t'('0) : d;
      for (int i = 1; i < `DELAY_DEPTH; i++) begin
        taps[i] <= taps[i-1];
      end
    end
  end

  assign q = taps[delay_sel];  // 16 taps cover every 4-bit select

endmodule

/* rx_control/rx_control.sv */
`timescale 1ns/10ps

module rx_control (
  input  logic        clock,
  input  logic        gtx_rx_reset,
  // AXI4-Lite slave
  input  logic [3:0]  awaddr,
  input  logic        awvalid,
  output logic        awready,
  input  logic [31:0] wdata,
  input  logic [3:0]  wstrb,
  input  logic        wvalid,
  output logic        wready,
  output logic [1:0]  bresp,
  output logic        bvalid,
  input  logic        bready,
  input  logic [3:0]  araddr,
  input  logic        arvalid,
  output logic        arready,
  output logic [31:0] rdata,
  output logic [1:0]  rresp,
  output logic        rvalid,
  input  logic        rready,
  // Link status in
  input  logic        link_good,
  input  logic        link_bad,
  input  logic        link_had_err,
  input  logic        sync_done,
  input  logic [7:0]  link_errcount,
  input  logic [15:0] prbs_errcount,
  input  logic        prbs_err,
  // Controls out
  output logic        prbs_en,
  output logic        pol_swap,
  output logic [3:0]  delay_sel,
  output logic        clear_counts,  // One-cycle pulse
  output logic        gate_link      // Zero the comparator data
);

  import comp_rx_pkg::*;

  localparam logic [1:0] RESP_OKAY = 2'b00;

  logic         aw_seen;     // Address waiting for its data
  logic         w_seen;      // Data waiting for its address
  logic [3:0]   aw_addr_q;
  logic [31:0]  w_data_q;
  logic [3:0]   w_strb_q;
  logic         aw_hs;
  logic         w_hs;
  logic         wr_fire;     // Both halves present, write now
  rx_reg_addr_t wr_addr;
  logic [31:0]  wr_data;
  logic [3:0]   wr_strb;
  rx_reg_addr_t rd_addr;
  logic [31:0]  rd_mux;
  logic [15:0]  err_count_sel;
  logic         prbs_err_seen;  // Sticky PRBS error for STATUS

  // --------------------
  // Write channel
  // --------------------
  assign awready = ~aw_seen & ~bvalid;
  assign wready  = ~w_seen & ~bvalid;
  assign aw_hs   = awvalid & awready;
  assign w_hs    = wvalid & wready;
  assign wr_fire = (aw_seen | aw_hs) & (w_seen | w_hs);
  assign wr_addr = rx_reg_addr_t'(aw_seen ? aw_addr_q : awaddr);
  assign wr_data = w_seen ? w_data_q : wdata;
  assign wr_strb = w_seen ? w_strb_q : wstrb;
  assign bresp   = RESP_OKAY;

  always_ff @(posedge clock or posedge gtx_rx_reset) begin
    if (gtx_rx_reset) begin
      aw_seen <= 1'b0;
      w_seen  <= 1'b0;
      bvalid  <= 1'b0;
    end else begin
      if (bvalid && bready) bvalid <= 1'b0;
      if (wr_fire) begin
        aw_seen <= 1'b0;
        w_seen  <= 1'b0;
        bvalid  <= 1'b1;  // Response the cycle after both halves
      end else begin
        if (aw_hs) aw_seen <= 1'b1;
        if (w_hs) w_seen <= 1'b1;
      end
    end
  end

  // Hold whichever half arrived first
  always_ff @(posedge clock) begin
    if (aw_hs) aw_addr_q <= awaddr;
    if (w_hs) begin
      w_data_q <= wdata;
      w_strb_q <= wstrb;
    end
  end

  // --------------------
  // Registers
  // --------------------
  always_ff @(posedge clock or posedge gtx_rx_reset) begin
    if (gtx_rx_reset) begin
      prbs_en      <= 1'b0;
      pol_swap     <= 1'b0;
      delay_sel    <= '0;
      clear_counts <= 1'b0;
    end else begin
      clear_counts <= 1'b0;
      if (wr_fire && wr_strb[0]) begin  // All fields live in byte 0
        case (wr_addr)
          CONTROL: begin
            prbs_en   <= wr_data[0];
            pol_swap  <= wr_data[1];
            delay_sel <= wr_data[7:4];
          end
          COMMAND: clear_counts <= wr_data[0];
          default: ;  // STATUS and ERR_COUNT are read only
        endcase
      end
    end
  end

  always_ff @(posedge clock or posedge gtx_rx_reset) begin
    if (gtx_rx_reset) prbs_err_seen <= 1'b0;
    else if (clear_counts) prbs_err_seen <= 1'b0;
    else if (prbs_err) prbs_err_seen <= 1'b1;
  end

  // --------------------
  // Read channel
  // --------------------
  assign arready       = ~rvalid;  // One read in flight
  assign rresp         = RESP_OKAY;
  assign rd_addr       = rx_reg_addr_t'(araddr);
  assign err_count_sel = prbs_en ? prbs_errcount : {8'h00, link_errcount};

  always_comb begin
    case (rd_addr)
      CONTROL:   rd_mux = {24'h0, delay_sel, 2'b00, pol_swap, prbs_en};
      STATUS:    rd_mux = {27'h0, prbs_err_seen, sync_done, link_had_err, link_bad, link_good};
      ERR_COUNT: rd_mux = {16'h0, err_count_sel};
      default:   rd_mux = 32'h0;  // COMMAND and holes read zero
    endcase
  end

  always_ff @(posedge clock or posedge gtx_rx_reset) begin
    if (gtx_rx_reset) rvalid <= 1'b0;
    else if (arvalid && arready) rvalid <= 1'b1;
    else if (rready) rvalid <= 1'b0;
  end

  always_ff @(posedge clock) begin
    if (arvalid && arready) rdata <= rd_mux;
  end

  // Keep bad or unproven links out of the trigger
  assign gate_link = ~link_good | link_bad;

  // Write response must stay up until the master takes it
  assert property (@(posedge clock) disable iff (gtx_rx_reset)
    bvalid && !bready |=> bvalid);

endmodule

/* logic/gtx_optical_rx.sv */
`timescale 1ns/10ps

module gtx_optical_rx (
  input  logic                    clock,
  input  logic                    gtx_rx_reset,
  // Deserialized fiber
  input  logic [15:0]             rx_word,
  input  logic                    rx_word_valid,
  input  logic                    rx_is_k,
  input  logic                    ttc_resync,  // Clears link monitor and PRBS count
  // AXI4-Lite slave
  input  logic [3:0]              awaddr,
  input  logic                    awvalid,
  output logic                    awready,
  input  logic [31:0]             wdata,
  input  logic [3:0]              wstrb,
  input  logic                    wvalid,
  output logic                    wready,
  output logic [1:0]              bresp,
  output logic                    bvalid,
  input  logic                    bready,
  input  logic [3:0]              araddr,
  input  logic                    arvalid,
  output logic                    arready,
  output logic [31:0]             rdata,
  output logic [1:0]              rresp,
  output logic                    rvalid,
  input  logic                    rready,
  // Comparator data and link status
  output comp_rx_pkg::comp_data_t comp_data,
  output logic                    comp_data_valid,
  output logic                    rx_fc,
  output logic                    link_good,
  output logic                    link_bad,
  output logic                    link_had_err
);

  import comp_rx_pkg::*;

  comp_data_t frame_data;
  logic       frame_valid;
  logic       frame_err;
  logic       fc_seen;
  logic       sync_done;
  logic [7:0] link_errcount;
  logic [15:0] prbs_errcount;
  logic       prbs_err;
  logic       prbs_en;
  logic       pol_swap;
  logic [3:0] delay_sel;
  logic       clear_counts;
  logic       gate_link;
  frame_tag_t tag_d;  // Flags entering the tag delay line
  frame_tag_t tag_q;

  // --------------------
  // Fiber front end
  // --------------------
  comp_frame_aligner u_aligner (
    .clock, .gtx_rx_reset, .rx_word, .rx_word_valid, .rx_is_k, .pol_swap,
    .frame_data, .frame_valid, .frame_err, .fc_seen, .sync_done
  );

  link_monitor u_link_mon (
    .clock, .gtx_rx_reset, .frame_valid, .frame_err,
    .clear (clear_counts), .ttc_resync,
    .link_errcount, .link_good, .link_bad, .link_had_err
  );

  prbs_checker u_prbs (
    .clock, .gtx_rx_reset, .enable (prbs_en), .clear (clear_counts), .ttc_resync,
    .frame_data, .frame_valid, .prbs_errcount, .prbs_err
  );

  rx_control u_ctrl (
    .clock, .gtx_rx_reset,
    .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready, .araddr, .arvalid, .arready,
    .rdata, .rresp, .rvalid, .rready,
    .link_good, .link_bad, .link_had_err, .sync_done,
    .link_errcount, .prbs_errcount, .prbs_err,
    .prbs_en, .pol_swap, .delay_sel, .clear_counts, .gate_link
  );

  // --------------------
  // Bx delay, data and tags kept in step
  // --------------------
  assign tag_d.valid = frame_valid;
  assign tag_d.fc    = fc_seen;

  bx_delay_line #(.payload_t(comp_data_t)) u_data_dly (
    .clock, .gtx_rx_reset, .delay_sel, .zero_in (gate_link),
    .d (frame_data), .q (comp_data)
  );

  bx_delay_line #(.payload_t(frame_tag_t)) u_tag_dly (
    .clock, .gtx_rx_reset, .delay_sel, .zero_in (gate_link),
    .d (tag_d), .q (tag_q)
  );

  assign comp_data_valid = tag_q.valid;
  assign rx_fc           = tag_q.fc;  // Latency marker, same delay as data

endmodule

/* verif/tb_gtx_optical_rx.sv */
`timescale 1ns/10ps
`include "comp_rx_macros.svh"

module tb_gtx_optical_rx;

  import comp_rx_pkg::*;

  localparam int N_DELIVERY      = 40;  // Frames in the delivery test
  localparam int N_POL           = 12;
  localparam int MAX_ERRS        = 12;  // Each error is followed by one frame
  localparam int N_RESYNC        = 20;
  localparam int N_PRBS          = 30;
  localparam int TOTAL_FRAMES    = N_DELIVERY + N_POL + 2 * MAX_ERRS + N_RESYNC + N_PRBS;
  localparam int WATCHDOG_CYCLES = TOTAL_FRAMES * 5 + 2000;
  localparam int AXI_WAIT        = 20;  // Cycles before an AXI handshake counts as lost

  logic        clock;
  logic        gtx_rx_reset;
  logic [15:0] rx_word;
  logic        rx_word_valid;
  logic        rx_is_k;
  logic        ttc_resync;
  logic [3:0]  awaddr;
  logic        awvalid;
  logic        awready;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        wvalid;
  logic        wready;
  logic [1:0]  bresp;
  logic        bvalid;
  logic        bready;
  logic [3:0]  araddr;
  logic        arvalid;
  logic        arready;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rvalid;
  logic        rready;
  comp_data_t  comp_data;
  logic        comp_data_valid;
  logic        rx_fc;
  logic        link_good;
  logic        link_bad;
  logic        link_had_err;

  integer      seed;
  int          mismatches;
  int          failures;
  int          cycle_cnt;    // Rising edges since time zero
  comp_data_t  exp_q[$];     // Frames due on comp_data, oldest first
  int          due_q[$];     // Cycle in which each queued frame is due
  comp_data_t  want;
  int          due;
  int          fc_expected;
  int          fc_observed;
  logic [3:0]  ctrl_dly;     // delay_sel kept in every CONTROL write

  // Link and PRBS model
  int          m_err;
  int          m_run;
  int          m_prbs_cnt;
  logic        m_good;
  logic        m_bad;
  logic        m_had;
  logic        m_sync;
  logic        m_prbs_seen;
  logic        m_prbs_en;
  logic        m_pol;
  logic        m_seeded;
  comp_data_t  m_prev;

  gtx_optical_rx i_gtx_optical_rx (.*);

  initial clock = 1'b0;
  always #50 clock = ~clock;  // 100 ns bx clock

  always @(posedge clock) cycle_cnt++;  // Bx count for latency checks

  // --------------------
  // Model helpers
  // --------------------
  function automatic int rand_below(input int n);
    logic [31:0] r;
    r = $random(seed);
    return int'(r % n);
  endfunction

  function automatic comp_data_t rand_frame();
    logic [31:0] a;
    logic [31:0] b;
    a = $random(seed);
    b = $random(seed);
    return {a[15:0], b};
  endfunction

  // Fibonacci step, feedback from bits 47, 46, 20 and 19
  function automatic comp_data_t lfsr_next(input comp_data_t s);
    return {s[46:0], s[47] ^ s[46] ^ s[20] ^ s[19]};
  endfunction

  function automatic logic [31:0] exp_status();
    return {27'h0, m_prbs_seen, m_sync, m_had, m_bad, m_good};
  endfunction

  function automatic logic [31:0] exp_err_count();
    return m_prbs_en ? 32'(m_prbs_cnt) : 32'(m_err);
  endfunction

  task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // --------------------
  // Fiber stimulus
  // --------------------
  task automatic put_word(input logic [15:0] w, input logic k);
    @(posedge clock);
    #5;
    rx_word       = w;
    rx_is_k       = k;
    rx_word_valid = 1'b1;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clock);
      #5;
      rx_word_valid = 1'b0;
      rx_is_k       = 1'b0;
      rx_word       = 16'h0000;
    end
  endtask

  task automatic send_frame(input comp_data_t payload, input logic fc_mid);
    comp_data_t rx;
    logic       pass;
    rx   = m_pol ? ~payload : payload;  // What the aligner assembles
    pass = m_good && !m_bad;            // Gate state before this frame lands
    if (pass && fc_mid) fc_expected++;
    if (m_prbs_en) begin
      if (m_seeded && (rx != lfsr_next(m_prev))) begin
        m_prbs_cnt++;
        m_prbs_seen = 1'b1;
      end
      m_prev   = rx;
      m_seeded = 1'b1;
    end
    if (m_run < `LINK_GOOD_FRAMES) m_run++;
    if (m_run == `LINK_GOOD_FRAMES) m_good = 1'b1;
    m_sync = 1'b1;
    put_word(`K_START, 1'b1);
    put_word(payload[47:32], 1'b0);  // First word on top
    if (fc_mid) put_word(`K_FC, 1'b1);
    put_word(payload[31:16], 1'b0);
    put_word(payload[15:0], 1'b0);
    if (pass) begin
      exp_q.push_back(rx);
      due_q.push_back(cycle_cnt + 2 + int'(ctrl_dly));  // Aligner, then delay_sel + 1 taps
    end
    idle(1 + rand_below(3));
  endtask

  task automatic send_fc();
    if (m_good && !m_bad) fc_expected++;
    put_word(`K_FC, 1'b1);
    idle(1);
  endtask

  task automatic inject_error(input logic stray_k);
    comp_data_t junk;
    junk = rand_frame();
    if (stray_k) begin
      put_word(`K_START, 1'b1);
      put_word(junk[15:0], 1'b0);
      put_word(16'h001C, 1'b1);  // Comma that is neither start nor FC
      m_sync = 1'b1;
    end else begin
      put_word(junk[15:0], 1'b0);  // No start word before it
    end
    idle(1);
    m_err  = (m_err < 255) ? m_err + 1 : 255;
    m_had  = 1'b1;
    m_run  = 0;
    m_good = 1'b0;
    if (m_err >= `LINK_BAD_ERRS) m_bad = 1'b1;
  endtask

  task automatic clear_model(input logic by_command);
    m_err      = 0;
    m_bad      = 1'b0;
    m_had      = 1'b0;
    m_prbs_cnt = 0;
    m_seeded   = 1'b0;
    if (by_command) m_prbs_seen = 1'b0;  // Sticky PRBS flag only clears by command
  endtask

  // Let the delay line empty, then every sent frame must have shown up
  task automatic drain();
    idle(`DELAY_DEPTH + 4);
    if (exp_q.size() != 0) begin
      failures++;
      $display("%0d expected frames never appeared on comp_data", exp_q.size());
      exp_q.delete();
      due_q.delete();
    end
  endtask

  // --------------------
  // AXI4-Lite master
  // --------------------
  task automatic axi_write(input logic [3:0] addr, input logic [31:0] data);
    int   wait_cnt;
    logic aw_done;
    logic w_done;
    @(posedge clock);
    #5;
    awaddr   = addr;
    awvalid  = 1'b1;
    wdata    = data;
    wstrb    = 4'hF;
    wvalid   = 1'b1;
    bready   = 1'b1;
    wait_cnt = 0;
    while ((awvalid || wvalid) && (wait_cnt < AXI_WAIT)) begin
      @(negedge clock);
      aw_done = awvalid && awready;  // Handshake lands on the next edge
      w_done  = wvalid && wready;
      @(posedge clock);
      #5;
      if (aw_done) awvalid = 1'b0;
      if (w_done) wvalid = 1'b0;
      wait_cnt++;
    end
    if (awvalid || wvalid) begin
      failures++;
      $display("AXI write to offset %h was never accepted", addr);
      awvalid = 1'b0;
      wvalid  = 1'b0;
    end
    @(negedge clock);
    while (!bvalid && (wait_cnt < 2 * AXI_WAIT)) begin
      @(negedge clock);
      wait_cnt++;
    end
    if (!bvalid) begin
      failures++;
      $display("AXI write to offset %h got no response", addr);
    end
    check(64'(bresp), 64'd0, "bresp");
    @(posedge clock);
    #5;
    bready = 1'b0;
  endtask

  task automatic axi_read(input logic [3:0] addr, output logic [31:0] data);
    int   wait_cnt;
    logic accepted;
    @(posedge clock);
    #5;
    araddr   = addr;
    arvalid  = 1'b1;
    rready   = 1'b1;
    wait_cnt = 0;
    while (arvalid && (wait_cnt < AXI_WAIT)) begin
      @(negedge clock);
      accepted = arready;
      @(posedge clock);
      #5;
      if (accepted) arvalid = 1'b0;
      wait_cnt++;
    end
    if (arvalid) begin
      failures++;
      $display("AXI read of offset %h was never accepted", addr);
      arvalid = 1'b0;
    end
    @(negedge clock);
    while (!rvalid && (wait_cnt < 2 * AXI_WAIT)) begin
      @(negedge clock);
      wait_cnt++;
    end
    if (!rvalid) begin
      failures++;
      $display("AXI read of offset %h got no data", addr);
    end
    data = rdata;
    check(64'(rresp), 64'd0, "rresp");
    @(posedge clock);
    #5;
    rready = 1'b0;
  endtask

  task automatic read_expect(input logic [3:0] addr, input logic [31:0] exp, input string what);
    logic [31:0] d;
    axi_read(addr, d);
    check(64'(d), 64'(exp), what);
  endtask

  task automatic set_control(input logic prbs, input logic pol);
    logic [31:0] ctrl;
    ctrl = {24'h0, ctrl_dly, 2'b00, pol, prbs};
    axi_write(CONTROL, ctrl);
    if (!prbs) m_seeded = 1'b0;  // Checker reseeds once enabled again
    m_prbs_en = prbs;
    m_pol     = pol;
    read_expect(CONTROL, ctrl, "CONTROL readback");
  endtask

  // --------------------
  // Output monitor, sampled mid-cycle
  // --------------------
  always @(negedge clock) begin
    if (!gtx_rx_reset) begin
      if (rx_fc) fc_observed++;
      if (comp_data_valid) begin
        if (exp_q.size() == 0) begin
          failures++;
          $display("Frame %h appeared on comp_data when none was due", comp_data);
        end else begin
          want = exp_q.pop_front();
          due  = due_q.pop_front();
          check(64'(comp_data), 64'(want), "comp_data");
          check(64'(cycle_cnt), 64'(due), "comp_data_valid cycle");
        end
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clock);
    $display("Watchdog expired, the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Some tests failed");
    $finish;
  end

  // --------------------
  // Test sequence
  // --------------------
  initial begin
    comp_data_t state;
    comp_data_t sent;
    int         n_err;
    seed          = 32'hcf23159f;
    mismatches    = 0;
    failures      = 0;
    cycle_cnt     = 0;
    fc_expected   = 0;
    fc_observed   = 0;
    m_err         = 0;
    m_run         = 0;
    m_prbs_cnt    = 0;
    m_good        = 1'b0;
    m_bad         = 1'b0;
    m_had         = 1'b0;
    m_sync        = 1'b0;
    m_prbs_seen   = 1'b0;
    m_prbs_en     = 1'b0;
    m_pol         = 1'b0;
    m_seeded      = 1'b0;
    m_prev        = '0;
    gtx_rx_reset  = 1'b1;
    rx_word       = 16'h0000;
    rx_word_valid = 1'b0;
    rx_is_k       = 1'b0;
    ttc_resync    = 1'b0;
    awaddr        = 4'h0;
    awvalid       = 1'b0;
    wdata         = 32'h0;
    wstrb         = 4'h0;
    wvalid        = 1'b0;
    bready        = 1'b0;
    araddr        = 4'h0;
    arvalid       = 1'b0;
    rready        = 1'b0;
    repeat (16) @(posedge clock);
    #5;
    gtx_rx_reset = 1'b0;

    check(64'(comp_data_valid), 64'd0, "comp_data_valid after reset");
    check(64'(rx_fc), 64'd0, "rx_fc after reset");
    check(64'(link_good), 64'd0, "link_good after reset");
    check(64'(bvalid | rvalid), 64'd0, "AXI responses after reset");
    read_expect(CONTROL, 32'h0, "CONTROL after reset");
    read_expect(STATUS, 32'h0, "STATUS after reset");
    read_expect(ERR_COUNT, 32'h0, "ERR_COUNT after reset");

    // Delivery, link gated until the good run completes
    ctrl_dly = 4'(rand_below(16));
    set_control(1'b0, 1'b0);
    for (int i = 0; i < N_DELIVERY; i++) send_frame(rand_frame(), 1'b0);
    drain();
    read_expect(STATUS, exp_status(), "STATUS after delivery");

    // Inverted route plus latency markers
    set_control(1'b0, 1'b1);
    for (int i = 0; i < N_POL; i++) begin
      send_frame(rand_frame(), (i == 3) || (rand_below(4) == 0));
      if (rand_below(3) == 0) send_fc();
    end
    drain();
    check(64'(fc_observed), 64'(fc_expected), "rx_fc pulse count");
    set_control(1'b0, 1'b0);

    // Framing errors
    n_err = 1 + rand_below(MAX_ERRS);
    for (int i = 0; i < n_err; i++) begin
      inject_error(rand_below(2) == 0);
      send_frame(rand_frame(), 1'b0);
    end
    drain();
    read_expect(ERR_COUNT, exp_err_count(), "ERR_COUNT after link errors");
    check(64'(link_had_err), 64'd1, "link_had_err");
    check(64'(link_bad), 64'(m_err >= `LINK_BAD_ERRS), "link_bad");
    read_expect(STATUS, exp_status(), "STATUS after link errors");

    // TTC resync, then the good run rebuilds
    @(posedge clock);
    #5;
    ttc_resync = 1'b1;
    @(posedge clock);
    #5;
    ttc_resync = 1'b0;
    clear_model(1'b0);
    read_expect(ERR_COUNT, exp_err_count(), "ERR_COUNT after resync");
    read_expect(STATUS, exp_status(), "STATUS after resync");
    for (int i = 0; i < N_RESYNC; i++) begin
      send_frame(rand_frame(), 1'b0);
      idle(2);  // link_good trails frame_valid by one cycle
      check(64'(link_good), 64'(m_good), "link_good during recovery");
    end
    drain();

    // PRBS self-test with corrupted frames
    set_control(1'b1, 1'b0);
    state = rand_frame() | 48'h1;  // Never the all-zero lockup state
    for (int i = 0; i < N_PRBS; i++) begin
      sent = state;
      if ((i == 5) || (rand_below(6) == 0)) sent = state ^ (rand_frame() | 48'h1);
      send_frame(sent, 1'b0);
      state = lfsr_next(state);
    end
    drain();
    read_expect(ERR_COUNT, exp_err_count(), "PRBS ERR_COUNT");
    read_expect(STATUS, exp_status(), "STATUS after PRBS");

    // Clear from the COMMAND register
    axi_write(COMMAND, 32'h1);
    clear_model(1'b1);
    read_expect(ERR_COUNT, exp_err_count(), "ERR_COUNT after clear command");
    read_expect(STATUS, exp_status(), "STATUS after clear command");
    set_control(1'b0, 1'b0);
    read_expect(ERR_COUNT, exp_err_count(), "link ERR_COUNT after PRBS");
    check(64'(fc_observed), 64'(fc_expected), "final rx_fc pulse count");

    $display("Finished with %0d mismatches and %0d other errors", mismatches, failures);
    if (mismatches + failures == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* src.f */
+incdir+common
common/comp_rx_pkg.sv
logic/comp_frame_aligner.sv
logic/link_monitor.sv
logic/prbs_checker.sv
logic/bx_delay_line.sv
rx_control/rx_control.sv
logic/gtx_optical_rx.sv
verif/tb_gtx_optical_rx.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the gtx_optical_rx testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

if ! verilator --binary --timing --assert -j 0 \
    --top-module tb_gtx_optical_rx -f src.f --Mdir "$BUILD_DIR" -o sim_tb; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/sim_tb" | tee "$LOG"
if [ "${PIPESTATUS[0]}" -ne 0 ]; then
  echo "Simulation exited with an error"
  exit 1
fi

if grep -q "Some tests failed" "$LOG"; then
  echo "FAIL"
  exit 1
fi

echo "PASS"
exit 0
